/* verilog/dcache_pkg.sv */
// cache geometry, address, line and port types, referenced by scoped name from every block
`default_nettype none

package dcache_pkg;

  // geometry, four ways fixed by the tree replacement
  localparam int NUM_SETS = 32;
  localparam int NUM_WAYS = 4;

  typedef logic [8:0]  tag_t;
  typedef logic [4:0]  set_idx_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  way_onehot_t;

  // word offset must be zero for a legal access
  typedef struct packed {
    tag_t       tag;
    set_idx_t   set_index;
    logic [1:0] offset;
  } addr_t;

  typedef struct packed {
    logic  valid;
    logic  dirty;
    tag_t  tag;
    word_t data;
  } line_t;

  // single outstanding request toward the backing memory
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t data;
  } mem_req_t;

  typedef struct packed {
    logic  ready;
    word_t data;
  } mem_rsp_t;

  typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, FILL, DONE} ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/cache_way.sv */
// one cache way: tag, valid, dirty and data per set, with tag compare and synchronous write
`default_nettype none
`timescale 1ns/1ns

module cache_way (
  input  logic              clock,
  input  logic              reset,
  input  dcache_pkg::addr_t lookup_addr,
  input  logic              write_en,
  input  dcache_pkg::line_t write_line,
  output logic              hit,
  output dcache_pkg::line_t line
);

  dcache_pkg::line_t entries [dcache_pkg::NUM_SETS];

  // entry at the lookup set, also the victim candidate
  assign line = entries[lookup_addr.set_index];

  assign hit = line.valid && (line.tag == lookup_addr.tag);

  // only the state bits are cleared, tag and data stay as they are
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < dcache_pkg::NUM_SETS; i++) begin
        entries[i].valid <= 1'b0;
        entries[i].dirty <= 1'b0;
      end
    end else if (write_en) begin
      entries[lookup_addr.set_index] <= write_line;
    end
  end

endmodule

`default_nettype wire

/* verilog/plru_tree.sv */
// per-set 3-bit tree pseudo-LRU, gives the victim way and moves away from each accessed way
`default_nettype none
`timescale 1ns/1ns

module plru_tree (
  input  logic                    clock,
  input  logic                    reset,
  input  dcache_pkg::set_idx_t    set_index,
  input  logic                    access_en,
  input  dcache_pkg::way_onehot_t access_way,
  output dcache_pkg::way_onehot_t victim_way
);

  // bit0 picks the half, bit1 the low pair, bit2 the high pair
  logic [2:0] tree_bits [dcache_pkg::NUM_SETS];
  logic [2:0] cur_bits;

  assign cur_bits = tree_bits[set_index];

  always_comb begin
    if (!cur_bits[0]) begin
      victim_way = cur_bits[1] ? 4'b0010 : 4'b0001;
    end else begin
      victim_way = cur_bits[2] ? 4'b1000 : 4'b0100;
    end
  end

  // point the tree away from the way just used
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < dcache_pkg::NUM_SETS; i++) begin
        tree_bits[i] <= 3'b000;
      end
    end else if (access_en) begin
      case (access_way)
        4'b0001: begin
          tree_bits[set_index][0] <= 1'b1;
          tree_bits[set_index][1] <= 1'b1;
        end
        4'b0010: begin
          tree_bits[set_index][0] <= 1'b1;
          tree_bits[set_index][1] <= 1'b0;
        end
        4'b0100: begin
          tree_bits[set_index][0] <= 1'b0;
          tree_bits[set_index][2] <= 1'b1;
        end
        4'b1000: begin
          tree_bits[set_index][0] <= 1'b0;
          tree_bits[set_index][2] <= 1'b0;
        end
        default: begin
          tree_bits[set_index] <= cur_bits;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_array.sv */
// four-way storage with LRU tree, merges hits, steers writes and presents the victim line
`default_nettype none
`timescale 1ns/1ns

module dcache_array (
  input  logic              clock,
  input  logic              reset,
  input  dcache_pkg::addr_t addr,
  input  logic              write_en,
  input  logic              fill,
  input  dcache_pkg::word_t write_data,
  input  logic              write_dirty,
  output logic              hit,
  output dcache_pkg::word_t read_data,
  output dcache_pkg::line_t victim,
  output dcache_pkg::addr_t victim_addr
);

  dcache_pkg::way_onehot_t hit_way;
  dcache_pkg::way_onehot_t victim_way;
  dcache_pkg::way_onehot_t write_way;
  dcache_pkg::line_t       way_line [dcache_pkg::NUM_WAYS];
  dcache_pkg::line_t       write_line;
  logic                    tree_access;

  // every write leaves a valid line with the requested tag
  assign write_line = '{valid: 1'b1, dirty: write_dirty, tag: addr.tag, data: write_data};

  // fills go to the victim, stores to the way that hit
  assign write_way = fill ? victim_way : hit_way;

  for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
    cache_way i_way (
      .clock      (clock),
      .reset      (reset),
      .lookup_addr(addr),
      .write_en   (write_en && write_way[w]),
      .write_line (write_line),
      .hit        (hit_way[w]),
      .line       (way_line[w])
    );
  end

  // read hits and all writes count as an access
  assign tree_access = write_en || hit;

  plru_tree i_plru (
    .clock     (clock),
    .reset     (reset),
    .set_index (addr.set_index),
    .access_en (tree_access),
    .access_way(write_way),
    .victim_way(victim_way)
  );

  assign hit = |hit_way;

  // at most one way hits, so an OR merge is enough
  always_comb begin
    read_data = '0;
    victim    = '0;
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      if (hit_way[w]) begin
        read_data = read_data | way_line[w].data;
      end
      if (victim_way[w]) begin
        victim = victim | way_line[w];
      end
    end
  end

  assign victim_addr = '{tag: victim.tag, set_index: addr.set_index, offset: 2'b00};

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
// APB slave and miss FSM: lookup, dirty write-back, fill and completion of each transfer
`default_nettype none
`timescale 1ns/1ns

module dcache_ctrl (
  input  logic                 clock,
  input  logic                 reset,
  // APB slave
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  dcache_pkg::addr_t    paddr,
  input  dcache_pkg::word_t    pwdata,
  output dcache_pkg::word_t    prdata,
  output logic                 pready,
  output logic                 pslverr,
  // backing memory
  output dcache_pkg::mem_req_t mem_req,
  input  dcache_pkg::mem_rsp_t mem_rsp,
  // array side
  output dcache_pkg::addr_t    addr,
  output logic                 write_en,
  output logic                 fill,
  output dcache_pkg::word_t    write_data,
  output logic                 write_dirty,
  input  logic                 hit,
  input  dcache_pkg::word_t    read_data,
  input  dcache_pkg::line_t    victim,
  input  dcache_pkg::addr_t    victim_addr
);

  dcache_pkg::ctrl_state_t state;
  dcache_pkg::addr_t       look_addr;
  dcache_pkg::word_t       req_wdata;
  logic                    req_write;
  logic                    req_err;
  logic                    setup;

  assign setup = psel && !penable;

  // an unaligned request keeps the old lookup address so the cache sees no new access
  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= dcache_pkg::IDLE;
      look_addr <= '0;
      req_write <= 1'b0;
      req_err   <= 1'b0;
    end else begin
      case (state)
        dcache_pkg::IDLE: begin
          if (setup) begin
            state     <= dcache_pkg::LOOKUP;
            req_write <= pwrite;
            req_err   <= |paddr.offset;
            if (paddr.offset == 2'b00) begin
              look_addr <= paddr;
            end
          end
        end
        dcache_pkg::LOOKUP: begin
          if (req_err || hit) begin
            state <= dcache_pkg::DONE;
          end else if (victim.valid && victim.dirty) begin
            state <= dcache_pkg::WRITEBACK;
          end else begin
            state <= dcache_pkg::FILL;
          end
        end
        dcache_pkg::WRITEBACK: begin
          if (mem_rsp.ready) begin
            state <= dcache_pkg::FILL;
          end
        end
        dcache_pkg::FILL: begin
          if (mem_rsp.ready) begin
            state <= dcache_pkg::DONE;
          end
        end
        default: begin
          state <= dcache_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == dcache_pkg::IDLE && setup) begin
      req_wdata <= pwdata;
    end
  end

  // array requests
  assign addr        = look_addr;
  assign fill        = (state == dcache_pkg::FILL);
  assign write_en    = (fill && mem_rsp.ready) ||
                       (state == dcache_pkg::DONE && req_write && !req_err);
  assign write_data  = fill ? mem_rsp.data : req_wdata;
  // fills arrive clean, stores leave the line dirty
  assign write_dirty = (state == dcache_pkg::DONE);

  // held steady by the state until ready, since look_addr and the tree do not move
  always_comb begin
    mem_req.valid = (state == dcache_pkg::WRITEBACK) || fill;
    mem_req.write = (state == dcache_pkg::WRITEBACK);
    mem_req.addr  = mem_req.write ? victim_addr : look_addr;
    mem_req.data  = mem_req.write ? victim.data : '0;
  end

  assign pready  = (state == dcache_pkg::DONE);
  assign pslverr = pready && req_err;
  assign prdata  = (pready && !req_write && !req_err) ? read_data : '0;

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
// data cache top level, joins the controller and the storage array to the APB and memory ports
`default_nettype none
`timescale 1ns/1ns

module dcache_top (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  dcache_pkg::addr_t    paddr,
  input  dcache_pkg::word_t    pwdata,
  output dcache_pkg::word_t    prdata,
  output logic                 pready,
  output logic                 pslverr,
  output dcache_pkg::mem_req_t mem_req,
  input  dcache_pkg::mem_rsp_t mem_rsp
);

  dcache_pkg::addr_t addr;
  dcache_pkg::word_t write_data;
  dcache_pkg::word_t read_data;
  dcache_pkg::line_t victim;
  dcache_pkg::addr_t victim_addr;
  logic              write_en;
  logic              fill;
  logic              write_dirty;
  logic              hit;

  dcache_ctrl i_ctrl (
    .clock      (clock),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .addr       (addr),
    .write_en   (write_en),
    .fill       (fill),
    .write_data (write_data),
    .write_dirty(write_dirty),
    .hit        (hit),
    .read_data  (read_data),
    .victim     (victim),
    .victim_addr(victim_addr)
  );

  dcache_array i_array (
    .clock      (clock),
    .reset      (reset),
    .addr       (addr),
    .write_en   (write_en),
    .fill       (fill),
    .write_data (write_data),
    .write_dirty(write_dirty),
    .hit        (hit),
    .read_data  (read_data),
    .victim     (victim),
    .victim_addr(victim_addr)
  );

endmodule

`default_nettype wire

/* sim/dcache_monitor.sv */
// checker: reference model of memory, tags and LRU tree, compares every APB transfer
`default_nettype none
`timescale 1ns/1ns

module dcache_monitor (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  dcache_pkg::addr_t    paddr,
  input  dcache_pkg::word_t    pwdata,
  input  dcache_pkg::word_t    prdata,
  input  logic                 pready,
  input  logic                 pslverr,
  input  dcache_pkg::mem_req_t mem_req,
  input  dcache_pkg::mem_rsp_t mem_rsp,
  input  logic [2:0]           test_id,
  input  logic                 test_end,
  output int                   error_count,
  output int                   transfer_count
);

  dcache_pkg::word_t    golden [16384];
  dcache_pkg::tag_t     shadow_tag   [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
  logic                 shadow_valid [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
  logic                 shadow_dirty [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
  logic [2:0]           shadow_tree  [dcache_pkg::NUM_SETS];
  dcache_pkg::mem_req_t seen_ops [$];
  int                   cycle;
  int                   setup_cycle;
  int                   test_errors;
  int                   test_transfers;

  // same content the backing memory starts with
  function automatic dcache_pkg::word_t fill_pattern(input logic [13:0] word);
    return {word ^ 14'h1b3, 2'b01, word, 2'b10};
  endfunction

  function automatic int victim_of(input logic [2:0] bits);
    if (!bits[0]) begin
      return bits[1] ? 1 : 0;
    end
    return bits[2] ? 3 : 2;
  endfunction

  function automatic logic [2:0] tree_after(input logic [2:0] bits, input int way);
    logic [2:0] next;
    next = bits;
    case (way)
      0: begin
        next[0] = 1'b1;
        next[1] = 1'b1;
      end
      1: begin
        next[0] = 1'b1;
        next[1] = 1'b0;
      end
      2: begin
        next[0] = 1'b0;
        next[2] = 1'b1;
      end
      default: begin
        next[0] = 1'b0;
        next[2] = 1'b0;
      end
    endcase
    return next;
  endfunction

  function automatic int find_way(input int set_num, input dcache_pkg::tag_t tag);
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      if (shadow_valid[set_num][w] && shadow_tag[set_num][w] == tag) begin
        return w;
      end
    end
    return -1;
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1: return "cold read misses";
      3'd2: return "write then read hit";
      3'd3: return "conflict replacement";
      3'd4: return "unaligned access";
      3'd5: return "random mixed traffic";
      default: return "unnamed";
    endcase
  endfunction

  task automatic note_error();
    error_count++;
    test_errors++;
  endtask

  task automatic compare_value(input string name, input logic [49:0] expected,
                               input logic [49:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, got %h", name, expected, actual);
      note_error();
    end
  endtask

  task automatic check_transfer();
    dcache_pkg::mem_req_t expect_ops [$];
    dcache_pkg::mem_req_t op;
    int                   set_num;
    int                   way;
    set_num = paddr.set_index;
    transfer_count++;
    test_transfers++;
    if (paddr.offset != 2'b00) begin
      compare_value("pslverr", 1, pslverr);
      compare_value("prdata", 0, prdata);
    end else begin
      compare_value("pslverr", 0, pslverr);
      way = find_way(set_num, paddr.tag);
      if (way < 0) begin
        way = victim_of(shadow_tree[set_num]);
        if (shadow_valid[set_num][way] && shadow_dirty[set_num][way]) begin
          op.valid = 1'b1;
          op.write = 1'b1;
          op.addr  = '{tag: shadow_tag[set_num][way], set_index: paddr.set_index, offset: 2'b00};
          op.data  = golden[{shadow_tag[set_num][way], paddr.set_index}];
          expect_ops.push_back(op);
        end
        op = '{valid: 1'b1, write: 1'b0, addr: paddr, data: '0};
        expect_ops.push_back(op);
        shadow_tag[set_num][way]   = paddr.tag;
        shadow_valid[set_num][way] = 1'b1;
        shadow_dirty[set_num][way] = 1'b0;
      end
      shadow_tree[set_num] = tree_after(shadow_tree[set_num], way);
      if (pwrite) begin
        golden[{paddr.tag, paddr.set_index}] = pwdata;
        shadow_dirty[set_num][way] = 1'b1;
      end else begin
        compare_value("prdata", golden[{paddr.tag, paddr.set_index}], prdata);
      end
    end
    // hits and errors finish without the memory
    if (expect_ops.size() == 0 && cycle - setup_cycle != 2) begin
      $display("access to %h took %0d cycles instead of 2", paddr, cycle - setup_cycle);
      note_error();
    end
    if (seen_ops.size() != expect_ops.size()) begin
      $display("access to %h made %0d memory requests, expected %0d",
               paddr, seen_ops.size(), expect_ops.size());
      note_error();
    end else begin
      foreach (expect_ops[i]) begin
        compare_value("mem_req", expect_ops[i], seen_ops[i]);
      end
    end
    seen_ops.delete();
  endtask

  initial begin
    error_count    = 0;
    transfer_count = 0;
    cycle          = 0;
    setup_cycle    = 0;
    test_errors    = 0;
    test_transfers = 0;
    for (int i = 0; i < 16384; i++) begin
      golden[i] = fill_pattern(14'(i));
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
        shadow_tree[s] = 3'b000;
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
          shadow_valid[s][w] = 1'b0;
          shadow_dirty[s][w] = 1'b0;
        end
      end
      seen_ops.delete();
    end else begin
      cycle++;
      if (psel && !penable) begin
        setup_cycle = cycle;
      end
      if (mem_req.valid && mem_rsp.ready) begin
        seen_ops.push_back(mem_req);
      end
      if (psel && penable && pready) begin
        check_transfer();
      end
      if (test_end) begin
        $display("test %0d, %s: %0d transfers, %0d errors",
                 test_id, test_name(test_id), test_transfers, test_errors);
        test_errors    = 0;
        test_transfers = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* sim/dcache_chk.sv */
// protocol assertions for the APB and memory ports, bound into the cache top level
`default_nettype none
`timescale 1ns/1ns

module dcache_chk (
  input logic                 clock,
  input logic                 reset,
  input logic                 psel,
  input logic                 penable,
  input logic                 pready,
  input dcache_pkg::mem_req_t mem_req,
  input dcache_pkg::mem_rsp_t mem_rsp
);

  int assert_errors = 0;

  // request fields frozen until the memory takes it
  property mem_req_held;
    @(posedge clock) disable iff (reset)
      mem_req.valid && !mem_rsp.ready |=> $stable(mem_req);
  endproperty

  // memory traffic only inside an APB access phase
  property mem_in_access;
    @(posedge clock) disable iff (reset)
      mem_req.valid |-> psel && penable;
  endproperty

  property pready_in_access;
    @(posedge clock) disable iff (reset)
      pready |-> psel && penable;
  endproperty

  a_mem_req_held: assert property (mem_req_held) else begin
    assert_errors++;
    $error("memory request changed before ready");
  end

  a_mem_in_access: assert property (mem_in_access) else begin
    assert_errors++;
    $error("memory request outside an APB access phase");
  end

  a_pready_in_access: assert property (pready_in_access) else begin
    assert_errors++;
    $error("pready high outside an access phase");
  end

endmodule

bind dcache_top dcache_chk i_chk (
  .clock  (clock),
  .reset  (reset),
  .psel   (psel),
  .penable(penable),
  .pready (pready),
  .mem_req(mem_req),
  .mem_rsp(mem_rsp)
);

`default_nettype wire

/* sim/tb_dcache.sv */
// testbench top: clock, reset, APB stimulus, backing memory with random latency, run limit
`default_nettype none
`timescale 1ns/1ns

module tb_dcache;

  // 229 transfers in all, at most 16 cycles each with write-back and fill
  localparam int TRANSFER_COUNT  = 229;
  localparam int TRANSFER_CYCLES = 16;
  localparam int CYCLE_LIMIT     = 4 * (16 + TRANSFER_COUNT * TRANSFER_CYCLES);

  logic                 clock;
  logic                 reset;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  dcache_pkg::addr_t    paddr;
  dcache_pkg::word_t    pwdata;
  dcache_pkg::word_t    prdata;
  logic                 pready;
  logic                 pslverr;
  dcache_pkg::mem_req_t mem_req;
  dcache_pkg::mem_rsp_t mem_rsp;
  logic [2:0]           test_id;
  logic                 test_end;
  int                   error_count;
  int                   transfer_count;
  int                   cycle_count = 0;
  logic [15:0]          stim_lfsr;
  logic [15:0]          latency_lfsr;
  int                   wait_left;
  logic                 mem_busy;
  dcache_pkg::word_t    backing [16384];

  dcache_top i_dcache_top (
    .clock  (clock),
    .reset  (reset),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp)
  );

  dcache_monitor i_monitor (
    .clock         (clock),
    .reset         (reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .mem_req       (mem_req),
    .mem_rsp       (mem_rsp),
    .test_id       (test_id),
    .test_end      (test_end),
    .error_count   (error_count),
    .transfer_count(transfer_count)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic dcache_pkg::word_t fill_pattern(input logic [13:0] word);
    return {word ^ 14'h1b3, 2'b01, word, 2'b10};
  endfunction

  function automatic dcache_pkg::addr_t make_addr(input dcache_pkg::tag_t tag,
                                                  input dcache_pkg::set_idx_t set_index,
                                                  input logic [1:0] offset);
    return '{tag: tag, set_index: set_index, offset: offset};
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      value = {value[30:0], stim_lfsr[0]};
    end
  endtask

  // one APB transfer, then one idle cycle
  task automatic apb_access(input logic write, input dcache_pkg::addr_t address,
                            input dcache_pkg::word_t data);
    @(negedge clock);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = address;
    pwdata  = data;
    @(negedge clock);
    penable = 1'b1;
    while (!pready) begin
      @(negedge clock);
    end
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic mark_test_end();
    test_end = 1'b1;
    @(negedge clock);
    test_end = 1'b0;
  endtask

  // backing memory, 0 to 3 wait cycles per request
  always @(negedge clock) begin
    if (mem_rsp.ready) begin
      mem_rsp = '0;
    end else if (mem_req.valid) begin
      if (!mem_busy) begin
        mem_busy  = 1'b1;
        wait_left = 0;
        for (int i = 0; i < 2; i++) begin
          latency_lfsr = lfsr_next(latency_lfsr);
          wait_left = wait_left * 2 + latency_lfsr[0];
        end
      end
      if (wait_left == 0) begin
        mem_busy      = 1'b0;
        mem_rsp.ready = 1'b1;
        if (mem_req.write) begin
          backing[{mem_req.addr.tag, mem_req.addr.set_index}] = mem_req.data;
        end else begin
          mem_rsp.data = backing[{mem_req.addr.tag, mem_req.addr.set_index}];
        end
      end else begin
        wait_left--;
      end
    end
  end

  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("run stopped after %0d cycles with tests still running", cycle_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]       bits;
    logic              rnd_write;
    logic [2:0]        rnd_tag;
    logic [1:0]        rnd_set;
    dcache_pkg::addr_t a;
    reset        = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    mem_rsp      = '0;
    test_id      = 3'd0;
    test_end     = 1'b0;
    stim_lfsr    = 16'd36;
    latency_lfsr = 16'd36;
    wait_left    = 0;
    mem_busy     = 1'b0;
    for (int i = 0; i < 16384; i++) begin
      backing[i] = fill_pattern(14'(i));
    end
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    test_id = 3'd1;
    for (int i = 0; i < 6; i++) begin
      apb_access(1'b0, make_addr(9'(i + 1), 5'(i), 2'b00), '0);
    end
    mark_test_end();

    test_id = 3'd2;
    a = make_addr(9'd20, 5'd9, 2'b00);
    apb_access(1'b1, a, 32'hcafe_0001);
    apb_access(1'b0, a, '0);
    apb_access(1'b1, a, 32'hcafe_0002);
    apb_access(1'b0, a, '0);
    mark_test_end();

    // five dirty tags in set 12, then five clean tags in set 13
    test_id = 3'd3;
    for (int i = 0; i < 5; i++) begin
      apb_access(1'b1, make_addr(9'(40 + i), 5'd12, 2'b00), 32'h5000_0000 + i);
    end
    for (int i = 0; i < 5; i++) begin
      apb_access(1'b0, make_addr(9'(40 + i), 5'd12, 2'b00), '0);
    end
    for (int i = 0; i < 5; i++) begin
      apb_access(1'b0, make_addr(9'(60 + i), 5'd13, 2'b00), '0);
    end
    mark_test_end();

    test_id = 3'd4;
    a = make_addr(9'd30, 5'd2, 2'b00);
    apb_access(1'b1, a, 32'h1234_5678);
    apb_access(1'b1, make_addr(9'd30, 5'd2, 2'b01), 32'hdead_beef);
    apb_access(1'b0, make_addr(9'd30, 5'd2, 2'b10), '0);
    apb_access(1'b0, a, '0);
    mark_test_end();

    // eight tags over four sets keeps conflicts frequent
    test_id = 3'd5;
    for (int n = 0; n < 200; n++) begin
      draw_bits(1, bits);
      rnd_write = bits[0];
      draw_bits(3, bits);
      rnd_tag = bits[2:0];
      draw_bits(2, bits);
      rnd_set = bits[1:0];
      draw_bits(32, bits);
      apb_access(rnd_write, make_addr({6'd0, rnd_tag}, {3'd0, rnd_set}, 2'b00), bits);
    end
    mark_test_end();

    $display("tests 5, transfers %0d, check errors %0d, assertion errors %0d",
             transfer_count, error_count, i_dcache_top.i_chk.assert_errors);
    if (error_count == 0 && i_dcache_top.i_chk.assert_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/dcache_pkg.sv
verilog/cache_way.sv
verilog/plru_tree.sv
verilog/dcache_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/dcache_monitor.sv
sim/dcache_chk.sv
sim/tb_dcache.sv
